//--- Bender.yml
package:
  name: eth_tx

sources:
  - logic/eth_tx_pkg.sv
  - logic/eth_frame_builder.sv
  - logic/arp_announcer.sv
  - logic/eth_tx_arbiter.sv
  - logic/eth_tx_fifo.sv
  - logic/eth_mac_tx.sv
  - logic/eth_tx_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/eth_tx_tb.sv

//--- logic/arp_announcer.sv
`timescale 1ns/1ps

module arp_announcer (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,
  input  logic [31:0] ip_addr,
  output logic [7:0]  dat,
  output logic        val,
  output logic        last,
  input  logic        rdy
);

  localparam int FRAME_LEN = 42; // 14 header + 28 ARP

  logic             enable_q;
  logic             active;
  logic [5:0]       cnt;
  logic [31:0]      ip_q;
  logic [0:41][7:0] frame;
  logic             start;

  // Broadcast gratuitous request, sender and target IP both ours
  assign frame = {
    48'hffff_ffff_ffff,
    eth_tx_pkg::DEV_MAC,
    eth_tx_pkg::ETYPE_ARP,
    eth_tx_pkg::ARP_HTYPE,
    eth_tx_pkg::ARP_PTYPE,
    eth_tx_pkg::ARP_HLEN,
    eth_tx_pkg::ARP_PLEN,
    eth_tx_pkg::ARP_OPER_REQ,
    eth_tx_pkg::DEV_MAC, ip_q, // Sender
    48'h0, ip_q                // Target
  };

  assign start = enable && !enable_q && !active;
  assign dat   = frame[cnt];
  assign val   = active;
  assign last  = (cnt == 6'(FRAME_LEN - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q <= 1'b0;
      active   <= 1'b0;
      cnt      <= '0;
    end else begin
      enable_q <= enable;
      if (start) begin
        active <= 1'b1;
        cnt    <= '0;
      end else if (active && rdy) begin
        cnt <= cnt + 6'd1;
        if (last) active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) ip_q <= ip_addr; // Address for this announcement
  end

endmodule

//--- logic/eth_frame_builder.sv
`timescale 1ns/1ps

module eth_frame_builder (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,
  input  logic [7:0]  tx_dat,
  input  logic        tx_val,
  input  logic        tx_last,
  input  logic [47:0] tx_dst,
  input  logic [15:0] tx_type,
  output logic        tx_cts,
  output logic [7:0]  dat,
  output logic        val,
  output logic        last,
  input  logic        rdy
);

  localparam int PW = $clog2(eth_tx_pkg::MAX_PAYLOAD);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_HDR  = 2'd1;
  localparam logic [1:0] S_PAY  = 2'd2;
  localparam logic [1:0] S_DROP = 2'd3; // Discard tail past the limit

  logic [1:0]       state;
  logic [3:0]       hdr_cnt;
  logic [PW-1:0]    pay_cnt;
  logic [47:0]      dst_q;
  logic [15:0]      type_q;
  logic [0:13][7:0] hdr;
  logic             at_max;
  logic             take;

  assign hdr    = {dst_q, eth_tx_pkg::DEV_MAC, type_q};
  assign at_max = (pay_cnt == PW'(eth_tx_pkg::MAX_PAYLOAD - 1));
  assign take   = tx_val && tx_cts;

  // Header from latched fields, payload straight through
  always_comb begin
    dat    = tx_dat;
    val    = 1'b0;
    last   = 1'b0;
    tx_cts = 1'b0;
    case (state)
      S_HDR: begin
        dat = hdr[hdr_cnt];
        val = 1'b1;
      end
      S_PAY: begin
        val    = tx_val;
        last   = tx_last || at_max; // Force end at the limit
        tx_cts = rdy;
      end
      S_DROP:  tx_cts = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      hdr_cnt <= '0;
      pay_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: if (enable && tx_val) begin
          state   <= S_HDR;
          hdr_cnt <= '0;
        end
        S_HDR: if (rdy) begin
          hdr_cnt <= hdr_cnt + 4'd1;
          if (hdr_cnt == 4'd13) begin
            state   <= S_PAY;
            pay_cnt <= '0;
          end
        end
        S_PAY: if (take) begin
          pay_cnt <= pay_cnt + PW'(1);
          if (tx_last)     state <= S_IDLE;
          else if (at_max) state <= S_DROP;
        end
        default: if (take && tx_last) state <= S_IDLE;
      endcase
    end
  end

  // Destination and type held for the whole header
  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      dst_q  <= tx_dst;
      type_q <= tx_type;
    end
  end

endmodule

//--- logic/eth_mac_tx.sv
`timescale 1ns/1ps

module eth_mac_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] dat,
  input  logic       val,
  input  logic       last,
  output logic       rdy,
  output logic [7:0] gmii_dat,
  output logic       gmii_val
);

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_PRE  = 3'd1;
  localparam logic [2:0] S_SFD  = 3'd2;
  localparam logic [2:0] S_DATA = 3'd3;
  localparam logic [2:0] S_PAD  = 3'd4;
  localparam logic [2:0] S_FCS  = 3'd5;
  localparam logic [2:0] S_GAP  = 3'd6;

  logic [2:0]  state;
  logic [3:0]  cnt;  // Preamble, FCS and gap steps
  logic [8:0]  len;  // Frame bytes sent so far
  logic [31:0] crc;

  assign rdy = (state == S_DATA); // Frame fully stored, never stalls

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      cnt      <= '0;
      len      <= '0;
      crc      <= '1;
      gmii_dat <= '0;
      gmii_val <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          gmii_val <= 1'b0;
          cnt      <= '0;
          len      <= '0;
          crc      <= '1;
          if (val) state <= S_PRE;
        end
        S_PRE: begin
          gmii_dat <= eth_tx_pkg::PREAMBLE_BYTE;
          gmii_val <= 1'b1;
          cnt      <= cnt + 4'd1;
          if (cnt == 4'(eth_tx_pkg::PREAMBLE_LEN - 1)) state <= S_SFD;
        end
        S_SFD: begin
          gmii_dat <= eth_tx_pkg::SFD_BYTE;
          state    <= S_DATA;
        end
        //////////////////////////////
        // Frame body
        //////////////////////////////
        S_DATA: begin
          gmii_dat <= dat;
          crc      <= eth_tx_pkg::crc32_step(crc, dat);
          len      <= len + 9'd1;
          cnt      <= '0;
          if (last) begin
            if (len < 9'(eth_tx_pkg::MIN_FRAME - 1)) state <= S_PAD;
            else                                     state <= S_FCS;
          end
        end
        S_PAD: begin
          gmii_dat <= 8'h00;
          crc      <= eth_tx_pkg::crc32_step(crc, 8'h00);
          len      <= len + 9'd1;
          if (len == 9'(eth_tx_pkg::MIN_FRAME - 1)) state <= S_FCS;
        end
        S_FCS: begin
          gmii_dat <= ~crc[7:0]; // LSB first
          crc      <= crc >> 8;
          cnt      <= cnt + 4'd1;
          if (cnt == 4'd3) begin
            state <= S_GAP;
            cnt   <= '0;
          end
        end
        //////////////////////////////
        // Interframe gap
        //////////////////////////////
        S_GAP: begin
          gmii_val <= 1'b0;
          cnt      <= cnt + 4'd1;
          if (cnt == 4'(eth_tx_pkg::IFG_CYCLES - 1)) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- logic/eth_tx_arbiter.sv
`timescale 1ns/1ps

module eth_tx_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] arp_dat,
  input  logic       arp_val,
  input  logic       arp_last,
  output logic       arp_rdy,
  input  logic [7:0] usr_dat,
  input  logic       usr_val,
  input  logic       usr_last,
  output logic       usr_rdy,
  output logic [7:0] dat,
  output logic       val,
  output logic       last,
  input  logic       rdy
);

  logic lock;     // Frame in flight
  logic lock_arp; // Owner of the locked frame
  logic sel_arp;

  // ARP wins when free, owner kept until its last byte
  assign sel_arp = lock ? lock_arp : arp_val;

  assign dat     = sel_arp ? arp_dat  : usr_dat;
  assign val     = sel_arp ? arp_val  : usr_val;
  assign last    = sel_arp ? arp_last : usr_last;
  assign arp_rdy = rdy && sel_arp;
  assign usr_rdy = rdy && !sel_arp;

  always_ff @(posedge clk) begin
    if (rst) begin
      lock     <= 1'b0;
      lock_arp <= 1'b0;
    end else if (val && rdy) begin
      lock     <= !last;
      lock_arp <= sel_arp;
    end
  end

endmodule

//--- logic/eth_tx_fifo.sv
`timescale 1ns/1ps

module eth_tx_fifo (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] in_dat,
  input  logic       in_val,
  input  logic       in_last,
  output logic       in_rdy,
  output logic [7:0] out_dat,
  output logic       out_val,
  output logic       out_last,
  input  logic       out_rdy
);

  localparam int AW = $clog2(eth_tx_pkg::FIFO_DEPTH);

  logic [8:0]  mem [eth_tx_pkg::FIFO_DEPTH]; // {last, byte}
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;
  logic [AW:0]   frames; // Complete frames stored
  logic          wr;
  logic          rd;
  logic          frame_in;
  logic          frame_out;

  assign in_rdy   = (fill != (AW + 1)'(eth_tx_pkg::FIFO_DEPTH));
  assign out_val  = (frames != '0); // Whole frame ready, no underrun
  assign out_dat  = mem[rd_ptr][7:0];
  assign out_last = mem[rd_ptr][8];

  assign wr        = in_val && in_rdy;
  assign rd        = out_val && out_rdy;
  assign frame_in  = wr && in_last;
  assign frame_out = rd && out_last;

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= {in_last, in_dat};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      frames <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr + AW'(1);
      if (rd) rd_ptr <= rd_ptr + AW'(1);
      fill   <= fill + (AW + 1)'(wr) - (AW + 1)'(rd);
      frames <= frames + (AW + 1)'(frame_in) - (AW + 1)'(frame_out);
    end
  end

endmodule

//--- logic/eth_tx_pkg.sv
package eth_tx_pkg;

  //////////////////////////////
  // Frame constants
  //////////////////////////////
  localparam logic [47:0] DEV_MAC      = 48'h42_55_92_16_ee_31;
  localparam int          MAX_PAYLOAD  = 256; // Bytes after the header
  localparam int          MIN_FRAME    = 60;  // Without FCS
  localparam int          PREAMBLE_LEN = 7;
  localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0]  SFD_BYTE      = 8'hd5;
  localparam int          IFG_CYCLES   = 12;
  localparam int          FIFO_DEPTH   = 1024;

  //////////////////////////////
  // EtherType and ARP fields
  //////////////////////////////
  localparam logic [15:0] ETYPE_ARP    = 16'h0806;
  localparam logic [15:0] ARP_HTYPE    = 16'd1;     // Ethernet
  localparam logic [15:0] ARP_PTYPE    = 16'h0800;  // IPv4
  localparam logic [7:0]  ARP_HLEN     = 8'd6;
  localparam logic [7:0]  ARP_PLEN     = 8'd4;
  localparam logic [15:0] ARP_OPER_REQ = 16'd1;

  localparam logic [31:0] CRC_POLY     = 32'hedb8_8320; // Reflected CRC-32

  // One byte through the reflected CRC-32, LSB first
  function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

//--- logic/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        ip_set,
  input  logic [31:0] ip_addr,
  input  logic [7:0]  tx_dat,
  input  logic        tx_val,
  input  logic        tx_last,
  input  logic [47:0] tx_dst,
  input  logic [15:0] tx_type,
  output logic        tx_cts,
  output logic [7:0]  gmii_dat,
  output logic        gmii_val
);

  logic        ip_set_q;
  logic [31:0] ip_addr_q;

  logic [7:0] usr_dat, arp_dat, fifo_dat, mac_dat;
  logic       usr_val, arp_val, fifo_val, mac_val;
  logic       usr_last, arp_last, fifo_last, mac_last;
  logic       usr_rdy, arp_rdy, fifo_rdy, mac_rdy;

  // Nothing leaves until an address is held
  always_ff @(posedge clk) begin
    if (rst) begin
      ip_set_q  <= 1'b0;
      ip_addr_q <= '0;
    end else begin
      ip_set_q  <= ip_set;
      ip_addr_q <= ip_addr;
    end
  end

  //////////////////////////////
  // Frame sources
  //////////////////////////////
  eth_frame_builder u_builder (
    .clk(clk), .rst(rst), .enable(ip_set_q),
    .tx_dat(tx_dat), .tx_val(tx_val), .tx_last(tx_last),
    .tx_dst(tx_dst), .tx_type(tx_type), .tx_cts(tx_cts),
    .dat(usr_dat), .val(usr_val), .last(usr_last), .rdy(usr_rdy)
  );

  arp_announcer u_arp (
    .clk(clk), .rst(rst), .enable(ip_set_q), .ip_addr(ip_addr_q),
    .dat(arp_dat), .val(arp_val), .last(arp_last), .rdy(arp_rdy)
  );

  eth_tx_arbiter u_arb (
    .clk(clk), .rst(rst),
    .arp_dat(arp_dat), .arp_val(arp_val), .arp_last(arp_last), .arp_rdy(arp_rdy),
    .usr_dat(usr_dat), .usr_val(usr_val), .usr_last(usr_last), .usr_rdy(usr_rdy),
    .dat(fifo_dat), .val(fifo_val), .last(fifo_last), .rdy(fifo_rdy)
  );

  //////////////////////////////
  // Buffer and MAC
  //////////////////////////////
  eth_tx_fifo u_fifo (
    .clk(clk), .rst(rst),
    .in_dat(fifo_dat), .in_val(fifo_val), .in_last(fifo_last), .in_rdy(fifo_rdy),
    .out_dat(mac_dat), .out_val(mac_val), .out_last(mac_last), .out_rdy(mac_rdy)
  );

  eth_mac_tx u_mac (
    .clk(clk), .rst(rst),
    .dat(mac_dat), .val(mac_val), .last(mac_last), .rdy(mac_rdy),
    .gmii_dat(gmii_dat), .gmii_val(gmii_val)
  );

endmodule

//--- test/eth_tx_ref.svh
`ifndef ETH_TX_REF_SVH
`define ETH_TX_REF_SVH

typedef logic [7:0] byte_q_t[$];

// Reflected CRC-32, one byte LSB first
function automatic logic [31:0] ref_crc_byte(input logic [31:0] crc, input logic [7:0] b);
  logic [31:0] c;
  int i;
  c = crc ^ {24'h0, b};
  for (i = 0; i < 8; i++) begin
    c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
  end
  return c;
endfunction

// Header plus payload, cut at the payload limit
function automatic byte_q_t data_frame(input logic [47:0] dst, input logic [15:0] etype,
                                       input byte_q_t payload);
  byte_q_t f;
  logic [111:0] hdr;
  int i;
  hdr = {dst, eth_tx_pkg::DEV_MAC, etype};
  for (i = 13; i >= 0; i--) f.push_back(hdr[8*i +: 8]);
  for (i = 0; i < payload.size() && i < eth_tx_pkg::MAX_PAYLOAD; i++) f.push_back(payload[i]);
  return f;
endfunction

// Gratuitous ARP request, broadcast, sender and target IP equal
function automatic byte_q_t arp_frame(input logic [31:0] ip);
  byte_q_t body;
  logic [223:0] arp;
  int i;
  arp = {16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0001, eth_tx_pkg::DEV_MAC, ip, 48'h0, ip};
  for (i = 27; i >= 0; i--) body.push_back(arp[8*i +: 8]);
  return data_frame(48'hffff_ffff_ffff, 16'h0806, body);
endfunction

// Preamble, SFD, frame padded to 60, FCS LSB first
function automatic byte_q_t on_wire(input byte_q_t frame);
  byte_q_t w;
  logic [31:0] crc;
  logic [7:0] b;
  int i;
  crc = 32'hffff_ffff;
  for (i = 0; i < 7; i++) w.push_back(8'h55);
  w.push_back(8'hd5);
  for (i = 0; i < frame.size() || i < 60; i++) begin
    b = (i < frame.size()) ? frame[i] : 8'h00;
    w.push_back(b);
    crc = ref_crc_byte(crc, b);
  end
  crc = ~crc;
  for (i = 0; i < 4; i++) w.push_back(crc[8*i +: 8]);
  return w;
endfunction

`endif

//--- test/eth_tx_tb.sv
`timescale 1ns/1ps

module eth_tx_tb;

  `include "eth_tx_ref.svh"

  localparam int TIMEOUT = 3000; // Cycles per wait
  localparam int IFG     = 12;

  logic        clk;
  logic        rst;
  logic        ip_set;
  logic [31:0] ip_addr;
  logic [7:0]  tx_dat;
  logic        tx_val;
  logic        tx_last;
  logic [47:0] tx_dst;
  logic [15:0] tx_type;
  logic        tx_cts;
  logic [7:0]  gmii_dat;
  logic        gmii_val;

  logic [31:0] rng_state;
  byte_q_t     pay;      // Payload of the next user frame
  byte_q_t     got;      // Last collected frame
  byte_q_t     rx_bytes; // Raw bytes seen on gmii
  int          rx_lens[$];

  eth_tx_top dut (
    .clk(clk), .rst(rst), .ip_set(ip_set), .ip_addr(ip_addr),
    .tx_dat(tx_dat), .tx_val(tx_val), .tx_last(tx_last), .tx_dst(tx_dst),
    .tx_type(tx_type), .tx_cts(tx_cts), .gmii_dat(gmii_dat), .gmii_val(gmii_val)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Checks and helpers
  //////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic void fill_random(input int n);
    pay.delete();
    repeat (n) pay.push_back(8'(next_rand()));
  endfunction

  // Collector records one gmii_val burst per frame
  initial begin : gmii_monitor
    int cur;
    int idle;
    cur  = 0;
    idle = 100;
    forever begin
      @(negedge clk);
      if (gmii_val) begin
        if (cur == 0 && idle < IFG) check_eq("gmii_val low cycles before frame", idle, IFG);
        rx_bytes.push_back(gmii_dat);
        cur++;
      end else begin
        if (cur != 0) begin
          rx_lens.push_back(cur);
          cur  = 0;
          idle = 0;
        end
        idle++;
      end
    end
  end

  task automatic wait_frame(input string what);
    int n;
    int len;
    n = 0;
    while (rx_lens.size() == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rx_lens.size() == 0) begin
      stop_run($sformatf("Timeout: no %s frame on gmii within %0d cycles", what, TIMEOUT));
    end else begin
      len = rx_lens.pop_front();
      got.delete();
      repeat (len) got.push_back(rx_bytes.pop_front());
    end
  endtask

  task automatic compare_frame(input byte_q_t act, input byte_q_t exp, input string what);
    int i;
    check_eq($sformatf("%s frame length", what), act.size(), exp.size());
    for (i = 0; i < exp.size(); i++) begin
      check_eq($sformatf("%s gmii_dat byte %0d", what, i), act[i], exp[i]);
    end
  endtask

  task automatic quiet_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      check_eq("gmii_val", gmii_val, 1'b0);
    end
    @(posedge clk);
  endtask

  // Byte held until tx_cts was high at the edge that took it
  task automatic send_byte(input logic [7:0] b, input logic lst);
    int n;
    logic taken;
    tx_dat  <= b;
    tx_val  <= 1'b1;
    tx_last <= lst;
    n       = 0;
    taken   = 1'b0;
    while (!taken && n < TIMEOUT) begin
      @(negedge clk);
      taken = tx_cts;
      @(posedge clk);
      n++;
    end
    if (!taken) stop_run("Timeout: tx_cts never accepted a user byte");
  endtask

  task automatic send_frame(input logic [47:0] dst, input logic [15:0] typ, input logic stall);
    int i;
    logic [31:0] r;
    tx_dst  <= dst;
    tx_type <= typ;
    for (i = 0; i < pay.size(); i++) begin
      r = next_rand();
      if (stall && r[1:0] == 2'd0) begin
        tx_val <= 1'b0; // Gap between user bytes
        repeat (1 + r[3:2]) @(posedge clk);
      end
      send_byte(pay[i], i == pay.size() - 1);
    end
    tx_val  <= 1'b0;
    tx_last <= 1'b0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic test_gating();
    tx_dat <= 8'ha5;
    tx_val <= 1'b1; // Offered while no address is held
    repeat (200) begin
      @(negedge clk);
      check_eq("tx_cts", tx_cts, 1'b0);
      check_eq("gmii_val", gmii_val, 1'b0);
    end
    @(posedge clk);
    tx_val <= 1'b0;
    @(posedge clk);
  endtask

  task automatic test_arp();
    ip_addr <= 32'hc0a8_010a;
    ip_set  <= 1'b1;
    wait_frame("ARP");
    compare_frame(got, on_wire(arp_frame(32'hc0a8_010a)), "ARP");
    quiet_cycles(200);
  endtask

  task automatic test_short();
    fill_random(10);
    send_frame(48'h0012_3456_789a, 16'h0800, 1'b0);
    wait_frame("short");
    compare_frame(got, on_wire(data_frame(48'h0012_3456_789a, 16'h0800, pay)), "short");
  endtask

  task automatic test_long_stalls();
    fill_random(200);
    send_frame(48'h00aa_bbcc_ddee, 16'h86dd, 1'b1);
    wait_frame("long");
    compare_frame(got, on_wire(data_frame(48'h00aa_bbcc_ddee, 16'h86dd, pay)), "long");
  endtask

  task automatic test_limit();
    byte_q_t exp_long;
    fill_random(300);
    send_frame(48'h0a0b_0c0d_0e0f, 16'h0800, 1'b0);
    exp_long = on_wire(data_frame(48'h0a0b_0c0d_0e0f, 16'h0800, pay)); // First 256 kept
    fill_random(5);
    send_frame(48'h0a0b_0c0d_0e10, 16'h0801, 1'b0);
    wait_frame("truncated");
    compare_frame(got, exp_long, "truncated");
    wait_frame("follow-up");
    compare_frame(got, on_wire(data_frame(48'h0a0b_0c0d_0e10, 16'h0801, pay)), "follow-up");
  endtask

  task automatic test_contention();
    byte_q_t first;
    byte_q_t exp_usr;
    byte_q_t exp_arp;
    fill_random(64);
    exp_usr = on_wire(data_frame(48'h0200_0000_0042, 16'h88b5, pay));
    exp_arp = on_wire(arp_frame(32'h0a00_0117));
    ip_set  <= 1'b0; // One-cycle drop retriggers the announcement
    ip_addr <= 32'h0a00_0117;
    fork
      send_frame(48'h0200_0000_0042, 16'h88b5, 1'b0);
      begin
        @(posedge clk);
        ip_set <= 1'b1;
      end
    join
    wait_frame("first contention");
    first = got;
    wait_frame("second contention");
    if (first[8] == 8'hff) begin
      compare_frame(first, exp_arp, "ARP");
      compare_frame(got, exp_usr, "user");
    end else begin
      compare_frame(first, exp_usr, "user");
      compare_frame(got, exp_arp, "ARP");
    end
  endtask

  initial begin
    rng_state = 32'h30b2_613d;
    rst       = 1'b1;
    ip_set    = 1'b0;
    ip_addr   = '0;
    tx_dat    = '0;
    tx_val    = 1'b0;
    tx_last   = 1'b0;
    tx_dst    = '0;
    tx_type   = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_gating();
    test_arp();
    test_short();
    test_long_stalls();
    test_limit();
    test_contention();
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+test
logic/eth_tx_pkg.sv
logic/eth_frame_builder.sv
logic/arp_announcer.sv
logic/eth_tx_arbiter.sv
logic/eth_tx_fifo.sv
logic/eth_mac_tx.sv
logic/eth_tx_top.sv
test/eth_tx_tb.sv
